// File: list.f
+incdir+include
hw/icache_tag_pkg.sv
hw/tag_sram_64x48.sv
hw/tag_req_decode.sv
hw/tag_match_replace.sv
hw/tag_resp_out.sv
hw/icache_tag_top.sv
dv/tb_icache_tag.sv

// File: Makefile
# Verilator flow for the instruction cache tag store

VERILATOR ?= verilator
TOP       ?= tb_icache_tag
RTL_TOP   ?= icache_tag_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only when the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_icache_tag.sv
`timescale 1ns/100ps

`include "icache_tag_defs.svh"

module tb_icache_tag
  import icache_tag_pkg::*;
();

  // Drive edge to sampling negedge, the input edge plus two pipeline edges
  localparam int RESP_DELAY  = 3;
  localparam int N_RANDOM    = 120;
  localparam int DRAIN_LIMIT = 20;

  // Directed tags, all in one set
  localparam tag_t     TAG_A = 23'h0000AA;
  localparam tag_t     TAG_B = 23'h0000BB;
  localparam tag_t     TAG_C = 23'h0000CC;
  localparam set_idx_t SET_D = 6'd5;

  // One table row, hand expectation used when chk is set
  typedef struct packed {
    tag_op_e    op;
    line_addr_t addr;
    logic       chk;
    logic       hit;
    logic       way;
  } stim_row_t;

  // Outstanding response and the negedge count it is due at
  typedef struct packed {
    tag_resp_t   resp;
    int unsigned due;
    int unsigned row;
  } pend_t;

  logic      clk0;
  logic      init;
  logic      req_valid;
  tag_req_t  req;
  logic      resp_valid;
  tag_resp_t resp;

  stim_row_t   table_q[$];
  pend_t       pend_q[$];
  int unsigned cyc = 0;

  // Reference state, valid bits, tags and replacement bits
  logic mv [`ICT_SETS][`ICT_WAYS];
  tag_t mt [`ICT_SETS][`ICT_WAYS];
  logic mr [`ICT_SETS];

  icache_tag_top i_icache_tag_top (
    .clk0       (clk0),
    .init       (init),
    .req_valid  (req_valid),
    .req        (req),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  initial begin
    clk0 = 1'b0;
    forever #2 clk0 = ~clk0;
  end

  task automatic halt_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    halt_run();
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    halt_run();
  endtask

  task automatic check_resp(input tag_resp_t got, input tag_resp_t exp, input int unsigned row);
    if (got !== exp) begin
      report_mismatch($sformatf(
        "row %0d got %s addr %h hit %b way %b, expected %s addr %h hit %b way %b",
        row, got.op.name(), got.line_addr, got.hit, got.way,
        exp.op.name(), exp.line_addr, exp.hit, exp.way));
    end
  endtask

  // Reference model, one access in request order
  // A miss reports way 0
  task automatic model_access(input tag_op_e op, input line_addr_t addr,
                              output logic hit, output logic way);
    set_idx_t i;
    tag_t     t;
    logic     h0;
    logic     h1;
    logic     v;
    i   = addr[`ICT_IDX_W-1:0];
    t   = addr[`ICT_IDX_W +: `ICT_TAG_W];
    h0  = mv[i][0] && (mt[i][0] == t);
    h1  = mv[i][1] && (mt[i][1] == t);
    hit = h0 || h1;
    way = 1'b0;
    // Lower way wins
    if (!h0 && h1) begin
      way = 1'b1;
    end
    case (op)
      LOOKUP: begin
        if (hit) begin
          mr[i] = ~way;
        end
      end
      FILL: begin
        if (!hit) begin
          // Free way first, else replacement bit
          if (!mv[i][0]) begin
            v = 1'b0;
          end else if (!mv[i][1]) begin
            v = 1'b1;
          end else begin
            v = mr[i];
          end
          mv[i][v] = 1'b1;
          mt[i][v] = t;
          mr[i]    = ~v;
          way      = v;
        end
      end
      INVAL: begin
        if (hit) begin
          mv[i][way] = 1'b0;
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic add_row(input tag_op_e op, input tag_t tag, input set_idx_t idx,
                         input logic chk, input logic hit, input logic way);
    stim_row_t r;
    r.op   = op;
    r.addr = {tag, idx};
    r.chk  = chk;
    r.hit  = hit;
    r.way  = way;
    table_q.push_back(r);
  endtask

  // Mostly lookups, a few tags over a handful of sets to force evictions
  task automatic add_random_rows();
    logic [31:0] rnd;
    tag_op_e     op;
    for (int n = 0; n < N_RANDOM; n++) begin
      rnd = $urandom;
      if (rnd[9:6] < 4'd8) begin
        op = LOOKUP;
      end else if (rnd[9:6] < 4'd13) begin
        op = FILL;
      end else begin
        op = INVAL;
      end
      add_row(op, {21'h15500, rnd[4:3]}, {rnd[2:0], 3'b001}, 1'b0, 1'b0, 1'b0);
    end
  endtask

  // Response monitor, sampled mid-cycle
  always @(negedge clk0) begin
    pend_t p;
    if (!init) begin
      if (resp_valid) begin
        if (pend_q.size() == 0) begin
          report_problem("Response strobe seen with no request outstanding");
        end
        p = pend_q.pop_front();
        if (p.due != cyc) begin
          report_mismatch($sformatf("row %0d response at count %0d, due at %0d",
                                    p.row, cyc, p.due));
        end
        check_resp(resp, p.resp, p.row);
      end else if ((pend_q.size() != 0) && (pend_q[0].due <= cyc)) begin
        report_problem($sformatf("No response strobe for row %0d", pend_q[0].row));
      end
    end
    cyc <= cyc + 1;
  end

  initial begin
    stim_row_t r;
    pend_t     p;
    logic      hit;
    logic      way;
    void'($urandom(32'h2197));
    init      = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    foreach (mv[s, w]) mv[s][w] = 1'b0;
    foreach (mt[s, w]) mt[s][w] = '0;
    foreach (mr[s]) mr[s] = 1'b0;

    // Empty store after reset
    add_row(LOOKUP, TAG_A, SET_D, 1'b1, 1'b0, 1'b0);
    add_row(LOOKUP, 23'h7FFFFF, 6'h3F, 1'b1, 1'b0, 1'b0);
    add_row(LOOKUP, 23'h000000, 6'h00, 1'b1, 1'b0, 1'b0);
    // First fill, then refill of the same tag
    add_row(FILL, TAG_A, SET_D, 1'b1, 1'b0, 1'b0);
    add_row(LOOKUP, TAG_A, SET_D, 1'b1, 1'b1, 1'b0);
    add_row(FILL, TAG_A, SET_D, 1'b1, 1'b1, 1'b0);
    // Second way
    add_row(FILL, TAG_B, SET_D, 1'b1, 1'b0, 1'b1);
    add_row(LOOKUP, TAG_A, SET_D, 1'b1, 1'b1, 1'b0);
    add_row(LOOKUP, TAG_B, SET_D, 1'b1, 1'b1, 1'b1);
    // Way 0 hit last, so way 1 is the victim
    add_row(LOOKUP, TAG_A, SET_D, 1'b1, 1'b1, 1'b0);
    add_row(FILL, TAG_C, SET_D, 1'b1, 1'b0, 1'b1);
    add_row(LOOKUP, TAG_B, SET_D, 1'b1, 1'b0, 1'b0);
    add_row(LOOKUP, TAG_C, SET_D, 1'b1, 1'b1, 1'b1);
    add_row(LOOKUP, TAG_A, SET_D, 1'b1, 1'b1, 1'b0);
    // Invalidate, then reuse of the freed way
    add_row(INVAL, TAG_A, SET_D, 1'b1, 1'b1, 1'b0);
    add_row(LOOKUP, TAG_A, SET_D, 1'b1, 1'b0, 1'b0);
    add_row(LOOKUP, TAG_C, SET_D, 1'b1, 1'b1, 1'b1);
    add_row(FILL, TAG_B, SET_D, 1'b1, 1'b0, 1'b0);
    add_row(LOOKUP, TAG_B, SET_D, 1'b1, 1'b1, 1'b0);
    add_row(INVAL, TAG_A, SET_D, 1'b1, 1'b0, 1'b0);
    add_random_rows();

    repeat (2) @(posedge clk0);
    init <= 1'b0;
    @(posedge clk0);

    foreach (table_q[k]) begin
      r = table_q[k];
      model_access(r.op, r.addr, hit, way);
      if (r.chk) begin
        hit = r.hit;
        way = r.way;
      end
      p.resp.op        = r.op;
      p.resp.line_addr = r.addr;
      p.resp.hit       = hit;
      p.resp.way       = way;
      p.due            = cyc + RESP_DELAY;
      p.row            = k;
      pend_q.push_back(p);
      req_valid     <= 1'b1;
      req.op        <= r.op;
      req.line_addr <= r.addr;
      @(posedge clk0);
      // Write-back slot after fill or invalidate
      if (r.op != LOOKUP) begin
        req_valid <= 1'b0;
        @(posedge clk0);
      end
    end
    req_valid <= 1'b0;

    for (int w = 0; (w < DRAIN_LIMIT) && (pend_q.size() != 0); w++) begin
      @(posedge clk0);
    end
    if (pend_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      report_problem($sformatf("Timed out with %0d responses outstanding", pend_q.size()));
    end
  end

endmodule

// File: hw/icache_tag_top.sv
`timescale 1ns/100ps

module icache_tag_top
  import icache_tag_pkg::*;
(
  input  logic      clk0,
  input  logic      init,
  input  logic      req_valid,
  input  tag_req_t  req,
  output logic      resp_valid,
  output tag_resp_t resp
);

  // Port command and its write-back source
  sram_cmd_t sram_cmd;
  sram_cmd_t wb_cmd;
  tag_word_t rdata;

  // Request record waiting on the read word
  logic     stage_valid;
  tag_op_e  stage_op;
  tag_t     stage_tag;
  set_idx_t stage_idx;

  // Compare result heading for the output register
  logic      hit_valid;
  tag_resp_t hit_resp;

  tag_req_decode i_tag_req_decode (
    .clk0        (clk0),
    .init        (init),
    .req_valid   (req_valid),
    .req         (req),
    .wb_cmd      (wb_cmd),
    .sram_cmd    (sram_cmd),
    .stage_valid (stage_valid),
    .stage_op    (stage_op),
    .stage_tag   (stage_tag),
    .stage_idx   (stage_idx)
  );

  tag_sram_64x48 i_tag_sram_64x48 (
    .clk0  (clk0),
    .init  (init),
    .cmd   (sram_cmd),
    .rdata (rdata)
  );

  tag_match_replace i_tag_match_replace (
    .clk0        (clk0),
    .init        (init),
    .stage_valid (stage_valid),
    .stage_op    (stage_op),
    .stage_tag   (stage_tag),
    .stage_idx   (stage_idx),
    .rdata       (rdata),
    .wb_cmd      (wb_cmd),
    .hit_valid   (hit_valid),
    .hit_resp    (hit_resp)
  );

  tag_resp_out i_tag_resp_out (
    .clk0       (clk0),
    .init       (init),
    .hit_valid  (hit_valid),
    .hit_resp   (hit_resp),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

endmodule

// File: hw/tag_resp_out.sv
`timescale 1ns/100ps

module tag_resp_out
  import icache_tag_pkg::*;
(
  input  logic      clk0,
  input  logic      init,
  input  logic      hit_valid,
  input  tag_resp_t hit_resp,
  output logic      resp_valid,
  output tag_resp_t resp
);

  // Strobe lasts one cycle per staged response
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= hit_valid;
    end
  end

  // Payload only loads on a strobe
  // Last response stays visible between strobes
  always_ff @(posedge clk0) begin
    if (hit_valid) begin
      resp <= hit_resp;
    end
  end

endmodule

// File: hw/tag_match_replace.sv
`timescale 1ns/100ps

`include "icache_tag_defs.svh"

module tag_match_replace
  import icache_tag_pkg::*;
(
  input  logic      clk0,
  input  logic      init,
  input  logic      stage_valid,
  input  tag_op_e   stage_op,
  input  tag_t      stage_tag,
  input  set_idx_t  stage_idx,
  input  tag_word_t rdata,
  output sram_cmd_t wb_cmd,
  output logic      hit_valid,
  output tag_resp_t hit_resp
);

  // One replacement bit per set, names the next victim
  logic [`ICT_SETS-1:0] repl_q;

  tag_entry_t entry0;
  tag_entry_t entry1;
  logic       match0;
  logic       match1;
  logic       hit;
  logic       hit_way;
  logic       victim;
  logic       wr_en;
  logic       wr_way;
  logic       resp_way;
  tag_entry_t new_entry;

  assign entry0 = rdata.way0;
  assign entry1 = rdata.way1;

  // Tag compare per way
  assign match0 = entry0.valid && (entry0.tag == stage_tag);
  assign match1 = entry1.valid && (entry1.tag == stage_tag);
  assign hit    = match0 || match1;

  // Way 0 wins a double match, zero on a miss
  assign hit_way = !match0 && match1;

  // Free way first, else the replacement bit
  always_comb begin
    if (!entry0.valid) begin
      victim = 1'b0;
    end else if (!entry1.valid) begin
      victim = 1'b1;
    end else begin
      victim = repl_q[stage_idx];
    end
  end

  // Only fill miss and invalidate hit touch the array
  assign wr_en = stage_valid &&
                 (((stage_op == FILL) && !hit) || ((stage_op == INVAL) && hit));
  assign wr_way = (stage_op == FILL) ? victim : hit_way;

  // Fill writes a valid entry, invalidate writes zeros
  assign new_entry.valid = (stage_op == FILL);
  assign new_entry.tag   = (stage_op == FILL) ? stage_tag : '0;

  // Same entry in both halves, mask picks the lane
  always_comb begin
    wb_cmd           = '0;
    wb_cmd.cs        = wr_en;
    wb_cmd.we        = wr_en;
    wb_cmd.idx       = stage_idx;
    wb_cmd.word.way0 = new_entry;
    wb_cmd.word.way1 = new_entry;
    if (wr_en) begin
      wb_cmd.mask = wr_way ? 2'b10 : 2'b01;
    end
  end

  // Reported way is the victim on a fill miss
  assign resp_way = ((stage_op == FILL) && !hit) ? victim : hit_way;

  // Replacement update
  // Lookup hit and fill miss point away from the used way
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      repl_q <= '0;
    end else if (stage_valid) begin
      if ((stage_op == LOOKUP) && hit) begin
        repl_q[stage_idx] <= !hit_way;
      end else if ((stage_op == FILL) && !hit) begin
        repl_q[stage_idx] <= !victim;
      end
    end
  end

  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      hit_valid <= 1'b0;
    end else begin
      hit_valid <= stage_valid;
    end
  end

  // Staged response payload
  always_ff @(posedge clk0) begin
    if (stage_valid) begin
      hit_resp.op        <= stage_op;
      hit_resp.line_addr <= {stage_tag, stage_idx};
      hit_resp.hit       <= hit;
      hit_resp.way       <= resp_way;
    end
  end

  // Fill never duplicates a tag, so a set holds it at most once
  a_no_dup_tag: assert property (
    @(posedge clk0) disable iff (init)
    stage_valid |-> !(match0 && match1)
  );

endmodule

// File: hw/tag_req_decode.sv
`timescale 1ns/100ps

`include "icache_tag_defs.svh"

module tag_req_decode
  import icache_tag_pkg::*;
(
  input  logic      clk0,
  input  logic      init,
  input  logic      req_valid,
  input  tag_req_t  req,
  input  sram_cmd_t wb_cmd,
  output sram_cmd_t sram_cmd,
  output logic      stage_valid,
  output tag_op_e   stage_op,
  output tag_t      stage_tag,
  output set_idx_t  stage_idx
);

  // Address split, index in the low bits
  set_idx_t req_idx;
  tag_t     req_tag;

  assign req_idx = req.line_addr[`ICT_IDX_W-1:0];
  assign req_tag = req.line_addr[`ICT_IDX_W +: `ICT_TAG_W];

  // Port mux
  // Write-back owns the port, else a read of the requested set
  always_comb begin
    if (wb_cmd.cs) begin
      sram_cmd = wb_cmd;
    end else begin
      sram_cmd      = '0;
      sram_cmd.cs   = req_valid;
      sram_cmd.we   = 1'b0;
      sram_cmd.idx  = req_idx;
    end
  end

  // Stage valid follows the request strobe
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= req_valid;
    end
  end

  // Op, tag and index wait one cycle for the read word
  always_ff @(posedge clk0) begin
    if (req_valid) begin
      stage_op  <= req.op;
      stage_tag <= req_tag;
      stage_idx <= req_idx;
    end
  end

  // Write-back slot must be an idle request cycle
  a_no_req_on_wb: assert property (
    @(posedge clk0) disable iff (init)
    wb_cmd.cs |-> !req_valid
  );

  // Fill or invalidate is followed by one idle cycle
  a_rmw_spacing: assert property (
    @(posedge clk0) disable iff (init)
    (req_valid && (req.op != LOOKUP)) |=> !req_valid
  );

endmodule

// File: hw/tag_sram_64x48.sv
`timescale 1ns/100ps

`include "icache_tag_defs.svh"

module tag_sram_64x48
  import icache_tag_pkg::*;
(
  input  logic      clk0,
  input  logic      init,
  input  sram_cmd_t cmd,
  output tag_word_t rdata
);

  // Half a word per way lane
  localparam int LANE_W = `ICT_WORD_W / `ICT_WAYS;

  logic [`ICT_WORD_W-1:0] mem [`ICT_SETS];

  // Registered command, control bits
  logic cs_q;
  logic we_q;

  // Registered command, payload
  way_mask_t mask_q;
  set_idx_t  idx_q;
  tag_word_t word_q;

  // Control flops, chip select inactive out of reset
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      cs_q <= 1'b0;
      we_q <= 1'b0;
    end else begin
      cs_q <= cmd.cs;
      we_q <= cmd.we;
    end
  end

  // Address, mask and write data
  always_ff @(posedge clk0) begin
    mask_q <= cmd.mask;
    idx_q  <= cmd.idx;
    word_q <= cmd.word;
  end

  // Array access on the falling edge
  // Reset wipes every entry so all ways start invalid
  always_ff @(negedge clk0 or posedge init) begin
    if (init) begin
      for (int i = 0; i < `ICT_SETS; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else if (cs_q) begin
      if (we_q) begin
        // Way 0 lane, low half
        if (mask_q[0]) begin
          mem[idx_q][LANE_W-1:0] <= word_q.way0;
        end
        // Way 1 lane, high half
        if (mask_q[1]) begin
          mem[idx_q][`ICT_WORD_W-1:LANE_W] <= word_q.way1;
        end
      end else begin
        rdata <= tag_word_t'(mem[idx_q]);
      end
    end
  end

  // Writes always carry at least one lane
  a_wr_mask_nonzero: assert property (
    @(posedge clk0) disable iff (init)
    (cmd.cs && cmd.we) |-> (cmd.mask != '0)
  );

endmodule

// File: hw/icache_tag_pkg.sv
`include "icache_tag_defs.svh"

package icache_tag_pkg;

  // Plain vector types
  typedef logic [`ICT_IDX_W-1:0] set_idx_t;
  typedef logic [`ICT_TAG_W-1:0] tag_t;
  // Tag in the upper bits, set index in the lower bits
  typedef logic [`ICT_TAG_W+`ICT_IDX_W-1:0] line_addr_t;
  // One lane per way
  typedef logic [`ICT_WAYS-1:0] way_mask_t;

  // One way-entry, valid bit above the tag
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  // Full SRAM word, way 1 in the upper half
  typedef struct packed {
    tag_entry_t way1;
    tag_entry_t way0;
  } tag_word_t;

  typedef enum logic [1:0] {
    LOOKUP = 2'd0,
    FILL   = 2'd1,
    INVAL  = 2'd2
  } tag_op_e;

  typedef struct packed {
    tag_op_e    op;
    line_addr_t line_addr;
  } tag_req_t;

  // Port command, enables active high
  typedef struct packed {
    logic      cs;
    logic      we;
    way_mask_t mask;
    set_idx_t  idx;
    tag_word_t word;
  } sram_cmd_t;

  typedef struct packed {
    tag_op_e    op;
    line_addr_t line_addr;
    logic       hit;
    logic       way;
  } tag_resp_t;

endpackage

// File: include/icache_tag_defs.svh
`ifndef ICACHE_TAG_DEFS_SVH
`define ICACHE_TAG_DEFS_SVH

// Number of sets in the tag store
`define ICT_SETS 64

// Set index bits, log2 of the set count
`define ICT_IDX_W 6

// Tag bits per way-entry
`define ICT_TAG_W 23

// Associativity
`define ICT_WAYS 2

// One SRAM word holds both way-entries
`define ICT_WORD_W 48

`endif
